// File: src.f
+incdir+logic
logic/usb_pkg.sv
logic/dfu_pkg.sv
logic/ctrl_ifs.sv
logic/setup_capture.sv
logic/ctrl_xfer_fsm.sv
logic/request_handler.sv
logic/in_data_source.sv
logic/usb_dfu_top.sv
verification/usb_dfu_tb.sv

// File: Bender.yml
package:
  name: usb_dfu

sources:
  - include_dirs:
      - logic
    files:
      - logic/usb_pkg.sv
      - logic/dfu_pkg.sv
      - logic/ctrl_ifs.sv
      - logic/setup_capture.sv
      - logic/ctrl_xfer_fsm.sv
      - logic/request_handler.sv
      - logic/in_data_source.sv
      - logic/usb_dfu_top.sv
  - target: test
    files:
      - verification/usb_dfu_tb.sv

// File: verification/usb_dfu_tb.sv
module usb_dfu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_packet_size = 32;
  localparam int transfer_size   = 256;
  localparam int cycle_limit     = 4000; // about ten times the full set of tests

  logic       clk;
  logic       reset;
  logic       out_ep_req;
  logic       out_ep_grant;
  logic       out_ep_data_avail;
  logic       out_ep_setup;
  logic       out_ep_data_get;
  logic [7:0] out_ep_data;
  logic       out_ep_stall;
  logic       out_ep_acked;
  logic       in_ep_req;
  logic       in_ep_grant;
  logic       in_ep_data_free;
  logic       in_ep_data_put;
  logic [7:0] in_ep_data;
  logic       in_ep_data_done;
  logic       in_ep_stall;
  logic       in_ep_acked;
  logic [6:0] dev_addr;

  int          errors     = 0;
  int          checks     = 0;
  int          test_base  = 0; // error count when the current test began
  int          cycles     = 0;
  int          out_stalls = 0;
  int          in_stalls  = 0;
  logic [15:0] lfsr;
  logic [7:0]  rx_bytes [$];
  logic [7:0]  exp_bytes [$];

  usb_dfu_top #(
    .max_packet_size (max_packet_size),
    .transfer_size   (transfer_size)
  ) usb_dfu_top_inst (
    .clk               (clk),
    .reset             (reset),
    .out_ep_req        (out_ep_req),
    .out_ep_grant      (out_ep_grant),
    .out_ep_data_avail (out_ep_data_avail),
    .out_ep_setup      (out_ep_setup),
    .out_ep_data_get   (out_ep_data_get),
    .out_ep_data       (out_ep_data),
    .out_ep_stall      (out_ep_stall),
    .out_ep_acked      (out_ep_acked),
    .in_ep_req         (in_ep_req),
    .in_ep_grant       (in_ep_grant),
    .in_ep_data_free   (in_ep_data_free),
    .in_ep_data_put    (in_ep_data_put),
    .in_ep_data        (in_ep_data),
    .in_ep_data_done   (in_ep_data_done),
    .in_ep_stall       (in_ep_stall),
    .in_ep_acked       (in_ep_acked),
    .dev_addr          (dev_addr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // stall pulse counters and the run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (out_ep_stall) out_stalls <= out_stalls + 1;
    if (in_ep_stall) in_stalls <= in_stalls + 1;
    if (cycles >= cycle_limit) begin
      $display("run stopped after %0d cycles, a transfer never finished", cycles);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checking and bookkeeping
  //////////////////////////////////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %0h expected %0h", what, got, exp);
    end
  endtask

  task automatic compare_rx(input string what);
    check({what, " in_ep_data count"}, rx_bytes.size(), exp_bytes.size());
    for (int i = 0; i < exp_bytes.size(); i++) begin
      if (i < rx_bytes.size()) begin
        check($sformatf("%s in_ep_data byte %0d", what, i), rx_bytes[i], exp_bytes[i]);
      end
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == test_base) $display("%-20s ok", name);
    else $display("%-20s %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic random_byte(output logic [7:0] b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // host side of the endpoints
  //////////////////////////////////////////////////////////////////////

  task automatic apply_reset;
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check("dev_addr", dev_addr, 7'h00);
    check("in_ep_req", in_ep_req, 1'b0);
    check("in_ep_data_done", in_ep_data_done, 1'b0);
    check("in_ep_stall", in_ep_stall, 1'b0);
    check("out_ep_stall", out_ep_stall, 1'b0);
    check("out_ep_data_get", out_ep_data_get, 1'b0);
  endtask

  task automatic send_setup(input logic [7:0] bm_type, input logic [7:0] b_req,
                            input logic [15:0] w_value, input logic [15:0] w_length);
    logic [7:0] pkt [8];
    pkt = '{bm_type, b_req, w_value[7:0], w_value[15:8], 8'h00, 8'h00,
            w_length[7:0], w_length[15:8]};
    @(posedge clk);
    out_ep_data_avail <= 1'b1;
    out_ep_grant      <= 1'b1;
    out_ep_setup      <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      check("out_ep_req", out_ep_req, 1'b1); // both follow avail
      check("out_ep_data_get", out_ep_data_get, 1'b1);
      out_ep_data <= pkt[i]; // byte follows avail by one cycle
      if (i == 7) begin
        out_ep_data_avail <= 1'b0;
        out_ep_grant      <= 1'b0;
      end
    end
    @(posedge clk);
    check("out_ep_req", out_ep_req, 1'b0);
    check("out_ep_data_get", out_ep_data_get, 1'b0);
    out_ep_setup <= 1'b0;
  endtask

  task automatic read_in;
    int   n;
    logic done;
    rx_bytes.delete();
    n    = 0;
    done = 1'b0;
    in_ep_grant     <= 1'b1;
    in_ep_data_free <= 1'b1;
    while (!done && n < 100) begin
      @(posedge clk);
      if (in_ep_grant && in_ep_data_put) rx_bytes.push_back(in_ep_data);
      done = in_ep_data_done;
      n++;
    end
    in_ep_grant     <= 1'b0;
    in_ep_data_free <= 1'b0;
    if (!done) begin
      errors++;
      $display("IN data stage never ended with in_ep_data_done");
    end else begin
      in_ep_acked <= 1'b1;
      @(posedge clk);
      in_ep_acked <= 1'b0;
    end
  endtask

  task automatic ack_status_out; // zero-length OUT after IN data
    @(posedge clk);
    out_ep_acked <= 1'b1;
    @(posedge clk);
    out_ep_acked <= 1'b0;
  endtask

  task automatic ack_status_in;
    in_ep_acked <= 1'b1;
    @(posedge clk);
    in_ep_acked <= 1'b0;
  endtask

  task automatic wait_zlp;
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 50) begin
      @(posedge clk);
      seen = in_ep_data_done;
      n++;
    end
    if (!seen) begin
      errors++;
      $display("no zero-length status packet on the IN endpoint");
    end
  endtask

  task automatic send_out(input int count);
    logic [7:0] b;
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      random_byte(b);
      out_ep_data_avail <= 1'b1;
      out_ep_grant      <= 1'b1;
      out_ep_data       <= b;
    end
    @(posedge clk);
    out_ep_data_avail <= 1'b0;
    out_ep_grant      <= 1'b0;
    @(posedge clk);
    out_ep_acked <= 1'b1;
    @(posedge clk);
    out_ep_acked <= 1'b0;
    check("in_ep_data_done", in_ep_data_done, 1'b1); // status packet comes with the ack
  endtask

  task automatic get_in(input logic [7:0] bm_type, input logic [7:0] b_req,
                        input logic [15:0] w_value, input logic [15:0] w_length);
    send_setup(bm_type, b_req, w_value, w_length);
    read_in();
    ack_status_out();
  endtask

  task automatic no_data_request(input logic [7:0] bm_type, input logic [7:0] b_req);
    send_setup(bm_type, b_req, 16'h0000, 16'h0000);
    wait_zlp();
    ack_status_in();
  endtask

  task automatic dnload(input int count);
    send_setup(8'h21, 8'h01, 16'h0000, 16'(count));
    send_out(count);
    ack_status_in();
  endtask

  // GETSTATUS reply is status, poll timeout (3 bytes), state, string index
  task automatic expect_status(input logic [7:0] status, input logic [7:0] state);
    get_in(8'ha1, 8'h03, 16'h0000, 16'd6);
    exp_bytes = {status, 8'h01, 8'h00, 8'h00, state, 8'h00};
    compare_rx("GETSTATUS");
  endtask

  task automatic expect_state(input logic [7:0] state);
    get_in(8'ha1, 8'h05, 16'h0000, 16'd1);
    exp_bytes = {state};
    compare_rx("GETSTATE");
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state_reply;
    expect_status(8'h00, 8'h02); // OK, dfuIDLE
    expect_state(8'h02);
    finish_test("reset dfu state");
  endtask

  task automatic device_descriptor;
    get_in(8'h80, 8'h06, 16'h0100, 16'd64);
    exp_bytes = {8'd18, 8'h01, 8'h00, 8'h01, 8'h00, 8'h00, 8'h00, 8'(max_packet_size),
                 8'hfe, 8'hca, 8'h01, 8'h00, 8'h00, 8'h00, 8'h01, 8'h02, 8'h00, 8'h01};
    compare_rx("device");
    if (rx_bytes.size() > 7) check("bMaxPacketSize0", rx_bytes[7], max_packet_size);
    finish_test("device descriptor");
  endtask

  task automatic config_and_string;
    string text;
    get_in(8'h80, 8'h06, 16'h0200, 16'd9);
    // wTotalLength covers config, interface and DFU functional parts
    exp_bytes = {8'd9, 8'h02, 8'd27, 8'h00, 8'd1, 8'd1, 8'd0, 8'h80, 8'd50};
    compare_rx("config");
    get_in(8'h80, 8'h06, 16'h0302, 16'd255);
    text = "DFU Loader";
    exp_bytes = {8'(2 + 2 * text.len()), 8'h03};
    for (int i = 0; i < text.len(); i++) begin
      exp_bytes.push_back(text[i]);
      exp_bytes.push_back(8'h00); // utf-16 high byte
    end
    compare_rx("string 2");
    finish_test("config and string");
  endtask

  task automatic address_update;
    send_setup(8'h00, 8'h05, 16'h002a, 16'h0000);
    check("dev_addr", dev_addr, 7'h00);
    wait_zlp();
    @(posedge clk); // pending address is held by now
    check("dev_addr", dev_addr, 7'h00);
    ack_status_in();
    @(posedge clk);
    check("dev_addr", dev_addr, 7'h2a);
    finish_test("set address");
  endtask

  task automatic download_sequence;
    int base;
    dnload(4);
    expect_status(8'h00, 8'h05); // sync moves to dnload idle before the reply
    base = out_stalls;
    dnload(4);
    check("out_ep_stall pulses", out_stalls - base, 0);
    dnload(4); // state is now dfuDNLOAD_SYNC
    check("out_ep_stall pulses", out_stalls - base, 1);
    expect_status(8'h03, 8'h0a);
    no_data_request(8'h21, 8'h04); // CLRSTATUS
    expect_state(8'h02);
    dnload(4);
    no_data_request(8'h21, 8'h06); // ABORT
    expect_state(8'h02);
    finish_test("dnload sequence");
  endtask

  task automatic qualifier_stall;
    int base;
    int bytes;
    int dones;
    base  = in_stalls;
    bytes = 0;
    dones = 0;
    in_ep_grant     <= 1'b1;
    in_ep_data_free <= 1'b1;
    send_setup(8'h80, 8'h06, 16'h0600, 16'd10);
    repeat (12) begin // window for any IN byte after the stall
      @(posedge clk);
      if (in_ep_grant && in_ep_data_put) bytes++;
      if (in_ep_data_done) dones++;
    end
    in_ep_grant     <= 1'b0;
    in_ep_data_free <= 1'b0;
    check("in_ep_stall pulses", in_stalls - base, 1);
    check("in_ep_data count", bytes, 0);
    check("in_ep_data_done pulses", dones, 0);
    finish_test("qualifier stall");
  endtask

  initial begin
    reset             = 1'b1;
    out_ep_grant      = 1'b0;
    out_ep_data_avail = 1'b0;
    out_ep_setup      = 1'b0;
    out_ep_data       = 8'h00;
    out_ep_acked      = 1'b0;
    in_ep_grant       = 1'b0;
    in_ep_data_free   = 1'b0;
    in_ep_acked       = 1'b0;
    lfsr              = 16'd55220;

    apply_reset();
    reset_state_reply();
    device_descriptor();
    config_and_string();
    address_update();
    download_sequence();
    qualifier_stall();

    $display("%0d checks, %0d errors, %0d cycles", checks, errors, cycles);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: logic/usb_dfu_top.sv
module usb_dfu_top #(
  parameter int max_packet_size = 32,
  parameter int transfer_size   = 256
) (
  input  logic       clk,
  input  logic       reset,

  //////////////////////////////////////////////////////////////////////
  // out endpoint
  //////////////////////////////////////////////////////////////////////
  output logic       out_ep_req,
  input  logic       out_ep_grant,
  input  logic       out_ep_data_avail,
  input  logic       out_ep_setup,
  output logic       out_ep_data_get,
  input  logic [7:0] out_ep_data,
  output logic       out_ep_stall,
  input  logic       out_ep_acked,

  //////////////////////////////////////////////////////////////////////
  // in endpoint
  //////////////////////////////////////////////////////////////////////
  output logic       in_ep_req,
  input  logic       in_ep_grant,
  input  logic       in_ep_data_free,
  output logic       in_ep_data_put,
  output logic [7:0] in_ep_data,
  output logic       in_ep_data_done,
  output logic       in_ep_stall,
  input  logic       in_ep_acked,

  output logic [6:0] dev_addr
);

  setup_if setup_bus ();
  xfer_if  xfer_bus ();

  setup_capture setup_capture_inst (
    .clk               (clk),
    .reset             (reset),
    .out_ep_data_avail (out_ep_data_avail),
    .out_ep_grant      (out_ep_grant),
    .out_ep_setup      (out_ep_setup),
    .out_ep_data       (out_ep_data),
    .stage_end_status  (xfer_bus.stage_end_status),
    .setup             (setup_bus.capture)
  );

  ctrl_xfer_fsm ctrl_xfer_fsm_inst (
    .clk               (clk),
    .reset             (reset),
    .setup             (setup_bus.fsm),
    .xfer              (xfer_bus.fsm),
    .out_ep_data_avail (out_ep_data_avail),
    .out_ep_grant      (out_ep_grant),
    .out_ep_setup      (out_ep_setup),
    .out_ep_acked      (out_ep_acked),
    .in_ep_data_free   (in_ep_data_free),
    .in_ep_grant       (in_ep_grant),
    .in_ep_acked       (in_ep_acked),
    .out_ep_req        (out_ep_req),
    .out_ep_data_get   (out_ep_data_get),
    .in_ep_req         (in_ep_req),
    .in_ep_data_put    (in_ep_data_put),
    .in_ep_data_done   (in_ep_data_done)
  );

  request_handler request_handler_inst (
    .clk          (clk),
    .reset        (reset),
    .setup        (setup_bus.fsm),
    .xfer         (xfer_bus.handler),
    .dev_addr     (dev_addr),
    .in_ep_stall  (in_ep_stall),
    .out_ep_stall (out_ep_stall)
  );

  in_data_source #(
    .max_packet_size (max_packet_size),
    .transfer_size   (transfer_size)
  ) in_data_source_inst (
    .clk   (clk),
    .reset (reset),
    .xfer  (xfer_bus.source)
  );

  assign in_ep_data = xfer_bus.data;

endmodule

// File: logic/in_data_source.sv
module in_data_source #(
  parameter int max_packet_size = 32,
  parameter int transfer_size   = 256
) (
  input  logic   clk,
  input  logic   reset,
  xfer_if.source xfer
);

  `include "descriptor_rom.svh"

  logic [7:0] rom [256];
  logic [7:0] rd_addr;
  logic [7:0] remaining;
  logic [7:0] rom_len;
  logic [7:0] load_len;
  logic [7:0] dfu_byte;

  initial begin
    foreach (rom[i]) rom[i] = 8'h00;
    foreach (device_desc[i]) rom[usb_pkg::rom_device_ofs + i] = device_desc[i];
    foreach (config_desc[i]) rom[usb_pkg::rom_config_ofs + i] = config_desc[i];
    foreach (lang_desc[i]) rom[usb_pkg::rom_lang_ofs + i] = lang_desc[i];
    foreach (string1_desc[i]) rom[usb_pkg::rom_string_ofs + i] = string1_desc[i];
    foreach (string2_desc[i]) begin
      rom[usb_pkg::rom_string_ofs + usb_pkg::string_slot + i] = string2_desc[i];
    end
  end

  // config is sized by wTotalLength, the rest by bLength
  assign rom_len = (xfer.start_addr == usb_pkg::rom_config_ofs) ?
                   rom[xfer.start_addr + 8'd2] : rom[xfer.start_addr];
  assign load_len = (xfer.src_sel == dfu_pkg::src_rom && xfer.length > rom_len) ?
                    rom_len : xfer.length;

  always_ff @(posedge clk) begin
    if (reset || xfer.stage_end_status) begin
      rd_addr   <= 8'h00;
      remaining <= 8'h00;
    end else if (xfer.load) begin
      rd_addr   <= xfer.start_addr;
      remaining <= load_len;
    end else if (xfer.advance) begin
      rd_addr   <= rd_addr + 8'd1;
      remaining <= remaining - 8'd1;
    end
  end

  // GETSTATUS reply layout
  always_comb begin
    case (rd_addr[2:0])
      3'd0:    dfu_byte = xfer.dfu_status;
      3'd1:    dfu_byte = dfu_pkg::poll_timeout;
      3'd4:    dfu_byte = xfer.dfu_state;
      default: dfu_byte = 8'h00;
    endcase
  end

  assign xfer.data      = (xfer.src_sel == dfu_pkg::src_dfu) ? dfu_byte : rom[rd_addr];
  assign xfer.src_empty = (remaining == 8'd0);

endmodule

// File: logic/request_handler.sv
module request_handler (
  input  logic       clk,
  input  logic       reset,
  setup_if.fsm       setup,
  xfer_if.handler    xfer,
  output logic [6:0] dev_addr,
  output logic       in_ep_stall,
  output logic       out_ep_stall
);

  localparam logic [7:0] len_desc      = 8'hff; // cut to the descriptor size by the source
  localparam logic [7:0] dfu_state_ofs = 8'h04; // bState in the status reply
  localparam logic [7:0] num_strings   = 8'd2;

  logic [8:0] req_code;
  logic [7:0] desc_type;
  logic [7:0] desc_index;
  logic       save_addr;
  logic [6:0] new_addr;

  assign req_code    = {setup.req.bm_request_type[5], setup.req.b_request};
  assign desc_type   = setup.req.w_value[15:8];
  assign desc_index  = setup.req.w_value[7:0];
  assign in_ep_stall = xfer.stall_in;

  always_ff @(posedge clk) begin
    if (reset) begin
      xfer.load       <= 1'b0;
      xfer.stall_in   <= 1'b0;
      xfer.src_sel    <= dfu_pkg::src_rom;
      xfer.start_addr <= 8'h00;
      xfer.length     <= 8'h00;
      xfer.dfu_status <= dfu_pkg::status_ok;
      xfer.dfu_state  <= dfu_pkg::dfu_idle;
      out_ep_stall    <= 1'b0;
      dev_addr        <= 7'd0;
      save_addr       <= 1'b0;
      new_addr        <= 7'd0;
    end else begin
      xfer.load     <= xfer.stage_end_setup;
      xfer.stall_in <= 1'b0;
      out_ep_stall  <= 1'b0;

      // old address stays valid until the status stage is done
      if (xfer.stage_end_status && save_addr) begin
        dev_addr  <= new_addr;
        save_addr <= 1'b0;
      end
      if (xfer.stage_end_data && xfer.dfu_state == dfu_pkg::dfu_dnbusy) begin
        xfer.dfu_state <= dfu_pkg::dfu_dnload_sync;
      end

      if (xfer.stage_end_setup) begin
        xfer.src_sel    <= dfu_pkg::src_rom;
        xfer.start_addr <= 8'h00;
        xfer.length     <= 8'h00;
        case (req_code)
          usb_pkg::req_get_descriptor: begin
            case (desc_type)
              usb_pkg::desc_device: begin
                xfer.start_addr <= usb_pkg::rom_device_ofs;
                xfer.length     <= len_desc;
              end
              usb_pkg::desc_config: begin
                xfer.start_addr <= usb_pkg::rom_config_ofs;
                xfer.length     <= len_desc;
              end
              usb_pkg::desc_string: begin
                if (desc_index == 8'd0) begin
                  xfer.start_addr <= usb_pkg::rom_lang_ofs;
                  xfer.length     <= len_desc;
                end else if (desc_index <= num_strings) begin
                  xfer.start_addr <= usb_pkg::rom_string_ofs +
                                     8'(usb_pkg::string_slot) * (desc_index - 8'd1);
                  xfer.length     <= len_desc;
                end else begin
                  xfer.stall_in <= 1'b1;
                end
              end
              usb_pkg::desc_qualifier: xfer.stall_in <= 1'b1; // full speed only
              default: xfer.stall_in <= 1'b1;
            endcase
          end
          usb_pkg::req_set_address: begin
            save_addr <= 1'b1;
            new_addr  <= setup.req.w_value[6:0];
          end
          usb_pkg::req_set_configuration: ; // one configuration, nothing to hold
          dfu_pkg::dfu_dnload: begin
            if (xfer.dfu_state == dfu_pkg::dfu_idle ||
                xfer.dfu_state == dfu_pkg::dfu_dnload_idle) begin
              xfer.dfu_state <= dfu_pkg::dfu_dnbusy;
            end else begin
              xfer.dfu_status <= dfu_pkg::status_err_write;
              xfer.dfu_state  <= dfu_pkg::dfu_error;
              out_ep_stall    <= 1'b1;
            end
          end
          dfu_pkg::dfu_getstatus: begin
            xfer.src_sel <= dfu_pkg::src_dfu;
            xfer.length  <= 8'd6;
            if (xfer.dfu_state == dfu_pkg::dfu_dnload_sync) begin
              xfer.dfu_state <= dfu_pkg::dfu_dnload_idle;
            end
          end
          dfu_pkg::dfu_getstate: begin
            xfer.src_sel    <= dfu_pkg::src_dfu;
            xfer.start_addr <= dfu_state_ofs;
            xfer.length     <= 8'd1;
          end
          dfu_pkg::dfu_clrstatus: begin
            xfer.dfu_status <= dfu_pkg::status_ok;
            xfer.dfu_state  <= dfu_pkg::dfu_idle;
          end
          dfu_pkg::dfu_abort: xfer.dfu_state <= dfu_pkg::dfu_idle;
          default: xfer.stall_in <= 1'b1;
        endcase
      end
    end
  end

endmodule

// File: logic/ctrl_xfer_fsm.sv
module ctrl_xfer_fsm (
  input  logic clk,
  input  logic reset,
  setup_if.fsm setup,
  xfer_if.fsm  xfer,
  input  logic out_ep_data_avail,
  input  logic out_ep_grant,
  input  logic out_ep_setup,
  input  logic out_ep_acked,
  input  logic in_ep_data_free,
  input  logic in_ep_grant,
  input  logic in_ep_acked,
  output logic out_ep_req,
  output logic out_ep_data_get,
  output logic in_ep_req,
  output logic in_ep_data_put,
  output logic in_ep_data_done
);

  usb_pkg::ctrl_stage_e stage;
  usb_pkg::ctrl_stage_e stage_next;
  logic [15:0]          data_length; // bytes left of wLength
  logic                 loaded;      // source counters hold this transfer
  logic                 all_sent;
  logic                 all_sent_q;
  logic                 zero_len_pkt;
  logic                 has_data;
  logic                 out_byte;

  assign has_data = |setup.req.w_length;
  assign out_byte = !out_ep_setup && out_ep_grant && out_ep_data_get && (data_length != 16'd0);
  assign all_sent = (stage == usb_pkg::data_in) && loaded &&
                    (xfer.src_empty || data_length == 16'd0);

  assign out_ep_req      = out_ep_data_avail;
  assign out_ep_data_get = out_ep_data_avail;
  assign in_ep_req       = (stage == usb_pkg::data_in) && loaded && !all_sent;
  assign in_ep_data_put  = in_ep_req && in_ep_data_free;
  assign xfer.advance    = in_ep_grant && in_ep_data_put;
  assign in_ep_data_done = (all_sent && !all_sent_q) || zero_len_pkt;

  //////////////////////////////////////////////////////////////////////
  // stage transitions
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    stage_next            = stage;
    xfer.stage_end_setup  = 1'b0;
    xfer.stage_end_data   = 1'b0;
    xfer.stage_end_status = 1'b0;
    zero_len_pkt          = 1'b0;
    case (stage)
      usb_pkg::idle: if (setup.setup_start) stage_next = usb_pkg::setup_in;
      usb_pkg::setup_in: if (setup.pkt_end) stage_next = usb_pkg::setup_done;
      usb_pkg::setup_done: begin
        xfer.stage_end_setup = 1'b1;
        if (has_data && setup.req.bm_request_type[7]) begin
          stage_next = usb_pkg::data_in;
        end else if (has_data) begin
          stage_next = usb_pkg::data_out;
        end else begin
          stage_next   = usb_pkg::status_in;
          zero_len_pkt = 1'b1; // status packet of a no-data request
        end
      end
      usb_pkg::data_in: begin
        if (xfer.stall_in) begin
          stage_next            = usb_pkg::idle;
          xfer.stage_end_data   = 1'b1;
          xfer.stage_end_status = 1'b1;
        end else if (in_ep_acked && all_sent) begin
          stage_next          = usb_pkg::status_out;
          xfer.stage_end_data = 1'b1;
        end
      end
      usb_pkg::data_out: begin
        if (out_ep_acked) begin
          stage_next          = usb_pkg::status_in;
          xfer.stage_end_data = 1'b1;
          zero_len_pkt        = 1'b1;
        end
      end
      usb_pkg::status_in: begin
        if (in_ep_acked && data_length != 16'd0) begin
          stage_next = usb_pkg::data_out; // next OUT packet of the data stage
        end else if (in_ep_acked) begin
          stage_next            = usb_pkg::idle;
          xfer.stage_end_status = 1'b1;
        end
      end
      usb_pkg::status_out: begin
        if (out_ep_acked) begin
          stage_next            = usb_pkg::idle;
          xfer.stage_end_status = 1'b1;
        end
      end
      default: stage_next = usb_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stage       <= usb_pkg::idle;
      data_length <= 16'd0;
      loaded      <= 1'b0;
      all_sent_q  <= 1'b0;
    end else begin
      stage      <= stage_next;
      all_sent_q <= all_sent;
      if (xfer.stage_end_setup) begin
        loaded <= 1'b0;
      end else if (xfer.load) begin
        loaded <= 1'b1;
      end
      if (xfer.stage_end_setup) begin
        data_length <= setup.req.w_length;
      end else if (xfer.advance || out_byte) begin
        data_length <= data_length - 16'd1;
      end
    end
  end

endmodule

// File: logic/setup_capture.sv
module setup_capture (
  input  logic       clk,
  input  logic       reset,
  input  logic       out_ep_data_avail,
  input  logic       out_ep_grant,
  input  logic       out_ep_setup,
  input  logic [7:0] out_ep_data,
  input  logic       stage_end_status,
  setup_if.capture   setup
);

  logic       data_valid; // endpoint presents a byte this cycle
  logic       avail_q;
  logic [2:0] byte_idx;
  logic [7:0] setup_bytes [8];

  always_ff @(posedge clk) begin
    if (reset) begin
      data_valid <= 1'b0;
      avail_q    <= 1'b0;
      byte_idx   <= 3'd0;
    end else begin
      data_valid <= out_ep_data_avail && out_ep_grant;
      avail_q    <= out_ep_data_avail;
      if (stage_end_status) begin
        byte_idx <= 3'd0;
      end else if (out_ep_setup && data_valid) begin
        byte_idx <= byte_idx + 3'd1; // wraps after the 8th byte
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_ep_setup && data_valid) begin
      setup_bytes[byte_idx] <= out_ep_data;
    end
  end

  assign setup.setup_start = out_ep_data_avail && !avail_q && out_ep_setup;
  assign setup.pkt_end     = !out_ep_data_avail && avail_q;

  // little endian fields, bytes 4 and 5 hold wIndex
  assign setup.req = '{
    bm_request_type: setup_bytes[0],
    b_request:       setup_bytes[1],
    w_value:         {setup_bytes[3], setup_bytes[2]},
    w_length:        {setup_bytes[7], setup_bytes[6]}
  };

endmodule

// File: logic/ctrl_ifs.sv
interface setup_if;
  usb_pkg::setup_req_t req;
  logic                setup_start; // first byte of a setup packet
  logic                pkt_end;     // any OUT packet finished

  modport capture (output req, setup_start, pkt_end);
  modport fsm (input req, setup_start, pkt_end);
endinterface

interface xfer_if;
  logic                 load;
  dfu_pkg::src_sel_e    src_sel;
  logic [7:0]           start_addr;
  logic [7:0]           length;
  logic                 stall_in;
  dfu_pkg::dfu_status_e dfu_status;
  dfu_pkg::dfu_state_e  dfu_state;
  logic                 stage_end_setup;
  logic                 stage_end_data;
  logic                 stage_end_status;
  logic                 advance;
  logic                 src_empty;
  logic [7:0]           data;

  modport handler (
    output load, src_sel, start_addr, length, stall_in, dfu_status, dfu_state,
    input  stage_end_setup, stage_end_data, stage_end_status
  );
  modport fsm (
    output stage_end_setup, stage_end_data, stage_end_status, advance,
    input  load, stall_in, src_empty
  );
  modport source (
    output src_empty, data,
    input  load, src_sel, start_addr, length, dfu_status, dfu_state, advance, stage_end_status
  );
endinterface

// File: logic/dfu_pkg.sv
package dfu_pkg;

  typedef enum logic [7:0] {
    status_ok        = 8'h00,
    status_err_write = 8'h03
  } dfu_status_e;

  typedef enum logic [7:0] {
    app_idle                = 8'h00,
    app_detach              = 8'h01,
    dfu_idle                = 8'h02,
    dfu_dnload_sync         = 8'h03,
    dfu_dnbusy              = 8'h04,
    dfu_dnload_idle         = 8'h05,
    dfu_manifest_sync       = 8'h06,
    dfu_manifest            = 8'h07,
    dfu_manifest_wait_reset = 8'h08,
    dfu_upload_idle         = 8'h09,
    dfu_error               = 8'h0a
  } dfu_state_e;

  // class requests, type bit set
  localparam logic [8:0] dfu_dnload    = 9'h101;
  localparam logic [8:0] dfu_getstatus = 9'h103;
  localparam logic [8:0] dfu_clrstatus = 9'h104;
  localparam logic [8:0] dfu_getstate  = 9'h105;
  localparam logic [8:0] dfu_abort     = 9'h106;

  typedef enum logic [1:0] {
    src_rom = 2'd0,
    src_dfu = 2'd1
  } src_sel_e;

  localparam logic [7:0] poll_timeout = 8'd1; // bwPollTimeout low byte in ms

endpackage

// File: logic/usb_pkg.sv
package usb_pkg;

  // setup packet fields, wIndex is not kept
  typedef struct packed {
    logic [7:0]  bm_request_type;
    logic [7:0]  b_request;
    logic [15:0] w_value;
    logic [15:0] w_length;
  } setup_req_t;

  typedef enum logic [2:0] {
    idle,
    setup_in,
    setup_done,
    data_in,
    data_out,
    status_in,
    status_out
  } ctrl_stage_e;

  // request code word is {type bit, bRequest}
  localparam logic [8:0] req_set_address       = 9'h005;
  localparam logic [8:0] req_get_descriptor    = 9'h006;
  localparam logic [8:0] req_set_configuration = 9'h009;

  localparam logic [7:0] desc_device    = 8'h01;
  localparam logic [7:0] desc_config    = 8'h02;
  localparam logic [7:0] desc_string    = 8'h03;
  localparam logic [7:0] desc_qualifier = 8'h06;

  // byte offsets in the descriptor ROM
  localparam logic [7:0] rom_device_ofs = 8'h00;
  localparam logic [7:0] rom_config_ofs = 8'h12;
  localparam logic [7:0] rom_lang_ofs   = 8'h2d;
  localparam logic [7:0] rom_string_ofs = 8'h40;
  localparam int         string_slot    = 32; // bytes per string descriptor

endpackage

// File: logic/descriptor_rom.svh
`ifndef DESCRIPTOR_ROM_SVH
`define DESCRIPTOR_ROM_SVH

localparam logic [7:0] device_desc [18] = '{
  8'd18, 8'h01, 8'h00, 8'h01,           // bcdUSB 1.00
  8'h00, 8'h00, 8'h00, 8'(max_packet_size),
  8'hfe, 8'hca, 8'h01, 8'h00,           // idVendor, idProduct
  8'h00, 8'h00, 8'd1, 8'd2,             // iManufacturer iProduct
  8'd0, 8'd1                            // no serial, one config
};

// config + DFU interface + DFU functional
localparam logic [7:0] config_desc [27] = '{
  8'd9, 8'h02, 8'd27, 8'h00, 8'd1, 8'd1, 8'd0, 8'h80, 8'd50,
  8'd9, 8'h04, 8'd0, 8'd0, 8'd0, 8'hfe, 8'h01, 8'h02, 8'd0,
  8'd9, 8'h21, 8'h09, 8'hff, 8'h00,     // download capable, will detach
  8'(transfer_size), 8'(transfer_size >> 8),
  8'h10, 8'h01                          // bcdDFUVersion 1.1
};

localparam logic [7:0] lang_desc [4] = '{8'd4, 8'h03, 8'h09, 8'h04}; // US English

localparam logic [7:0] string1_desc [10] = '{
  8'd10, 8'h03, "O", 8'h00, "p", 8'h00, "e", 8'h00, "n", 8'h00
};

localparam logic [7:0] string2_desc [22] = '{
  8'd22, 8'h03,
  "D", 8'h00, "F", 8'h00, "U", 8'h00, " ", 8'h00, "L", 8'h00,
  "o", 8'h00, "a", 8'h00, "d", 8'h00, "e", 8'h00, "r", 8'h00
};

`endif
